//--- logic/loopback_consts.svh
// PCS loopback constants
// Block widths, elastic buffer depth and the idle deletion threshold
// shared by the loopback packages and RTL

`ifndef LOOPBACK_CONSTS_SVH
`define LOOPBACK_CONSTS_SVH

// --------------------
// PCS block format
// --------------------
`define PCS_DATA_W 64        // Payload bits per block
`define PCS_KEEP_W 8         // One valid bit per byte
`define PCS_START_W 2        // Start on lane 0 or lane 4

// --------------------
// Elastic buffer
// --------------------
`define LB_DEPTH 8           // Blocks held, also the initial credits

// Idles are deleted while credits are at or below this level
`define LB_IDLE_DROP_TH 2

`endif

//--- logic/loopback_ctrl_pkg.sv
// Loopback control types
// Credit and occupancy counts between capture and buffer,
// overflow drop counter and the TX emitter states

`include "loopback_consts.svh"

package loopback_ctrl_pkg;

	// Holds 0 through LB_DEPTH, used for credits and buffer occupancy
	typedef logic [$clog2(`LB_DEPTH+1)-1:0] lb_credit_t;

	typedef logic [15:0] lb_count_t;  // Overflow drop count

	// TX emitter sequencing
	typedef enum logic [1:0] {
		EMIT_RESET = 2'd0,  // TX PCS held in reset
		EMIT_WAKE  = 2'd1,  // Second release stage
		EMIT_RUN   = 2'd2   // Normal loopback traffic
	} emit_state_t;

endpackage

//--- logic/loopback_fifo.sv
// Loopback elastic buffer
// Circular store of PCS blocks between RX capture and TX emitter.
// Each pop hands one credit back to the capture side, which keeps
// the store from ever overflowing
`timescale 1ns/1ns
`include "loopback_consts.svh"

module loopback_fifo (
	input  logic                      rx_clk,
	input  logic                      rst_n_i,
	input  logic                      push_i,
	input  pcs_types_pkg::pcs_block_t push_blk_i,
	input  logic                      pop_i,
	output pcs_types_pkg::pcs_block_t head_blk_o,
	output logic                      not_empty_o,
	output logic                      credit_ret_o
);
	import pcs_types_pkg::*;
	import loopback_ctrl_pkg::*;

	localparam int PTR_W = $clog2(`LB_DEPTH);

	pcs_block_t       mem_q [`LB_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	lb_credit_t       occ_q;
	logic             pop_ok;

	// Wraps at LB_DEPTH even when the depth is not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`LB_DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_W'(1);
	endfunction

	// --------------------
	// Storage
	// --------------------
	always_ff @(posedge rx_clk) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= push_blk_i;
		end
	end

	assign head_blk_o  = mem_q[rd_ptr_q];  // Visible the cycle after the push
	assign not_empty_o = (occ_q != '0);
	assign pop_ok      = pop_i & not_empty_o;
	assign credit_ret_o = pop_ok;          // One credit per block leaving

	// --------------------
	// Pointers and occupancy
	// --------------------
	always_ff @(posedge rx_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			occ_q    <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			end
			if (pop_ok) begin
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			end
			case ({push_i, pop_ok})
				2'b10:   occ_q <= occ_q + lb_credit_t'(1);
				2'b01:   occ_q <= occ_q - lb_credit_t'(1);
				default: occ_q <= occ_q;
			endcase
		end
	end

endmodule

//--- logic/pcs_loopback_top.sv
// PCS loopback top
// Returns decoded RX blocks to the TX PCS for FPGA link testing.
// Capture, elastic buffer and emitter share the rx_clk domain
`timescale 1ns/1ns

module pcs_loopback_top (
	input  logic                         rx_clk,
	input  logic                         rst_n_i,
	// RX PCS side
	input  pcs_types_pkg::pcs_block_t    rx_blk_i,
	input  logic                         rx_valid_i,
	// TX PCS side
	input  logic                         tx_ready_i,
	output pcs_types_pkg::pcs_block_t    tx_blk_o,
	output logic                         tx_nreset_o,
	// Status
	output loopback_ctrl_pkg::lb_count_t ovf_cnt_o
);
	import pcs_types_pkg::*;

	pcs_block_t push_blk;
	pcs_block_t head_blk;
	logic       push;
	logic       pop;
	logic       not_empty;
	logic       credit_ret;

	// --------------------
	// RX capture
	// --------------------
	pcs_rx_capture u_pcs_rx_capture (
		.rx_clk       (rx_clk),
		.rst_n_i      (rst_n_i),
		.rx_blk_i     (rx_blk_i),
		.rx_valid_i   (rx_valid_i),
		.credit_ret_i (credit_ret),
		.push_o       (push),
		.push_blk_o   (push_blk),
		.ovf_cnt_o    (ovf_cnt_o)
	);

	// --------------------
	// Elastic buffer
	// --------------------
	loopback_fifo u_loopback_fifo (
		.rx_clk       (rx_clk),
		.rst_n_i      (rst_n_i),
		.push_i       (push),
		.push_blk_i   (push_blk),
		.pop_i        (pop),
		.head_blk_o   (head_blk),
		.not_empty_o  (not_empty),
		.credit_ret_o (credit_ret)
	);

	// --------------------
	// TX emitter
	// --------------------
	pcs_tx_emit u_pcs_tx_emit (
		.rx_clk      (rx_clk),
		.rst_n_i     (rst_n_i),
		.head_blk_i  (head_blk),
		.not_empty_i (not_empty),
		.tx_ready_i  (tx_ready_i),
		.pop_o       (pop),
		.tx_blk_o    (tx_blk_o),
		.tx_nreset_o (tx_nreset_o)
	);

endmodule

//--- logic/pcs_rx_capture.sv
// PCS RX capture
// Registers decoded RX blocks and forwards them into the loopback
// buffer under credit control. Idles are deleted when space runs
// low, and data blocks arriving with no credit left are counted
`timescale 1ns/1ns
`include "loopback_consts.svh"

module pcs_rx_capture (
	input  logic                         rx_clk,
	input  logic                         rst_n_i,
	input  pcs_types_pkg::pcs_block_t    rx_blk_i,
	input  logic                         rx_valid_i,
	input  logic                         credit_ret_i,
	output logic                         push_o,
	output pcs_types_pkg::pcs_block_t    push_blk_o,
	output loopback_ctrl_pkg::lb_count_t ovf_cnt_o
);
	import pcs_types_pkg::*;
	import loopback_ctrl_pkg::*;

	pcs_block_t cap_q;
	logic       cap_vld_q;
	lb_credit_t credit_q;
	logic       cap_idle;
	logic       no_credit;
	logic       low_space;
	logic       drop_ovf;

	// --------------------
	// Input stage
	// --------------------
	always_ff @(posedge rx_clk) begin
		if (rx_valid_i) begin
			cap_q <= rx_blk_i;  // Latest valid block
		end
	end

	always_ff @(posedge rx_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cap_vld_q <= 1'b0;
		end else begin
			cap_vld_q <= rx_valid_i;
		end
	end

	// --------------------
	// Push decision
	// --------------------
	assign cap_idle  = cap_q.ctrl & cap_q.idle;
	assign no_credit = (credit_q == '0);
	assign low_space = (credit_q <= lb_credit_t'(`LB_IDLE_DROP_TH));

	// Idles go first, data only stops at zero credit
	assign push_o     = cap_vld_q & ~no_credit & ~(cap_idle & low_space);
	assign drop_ovf   = cap_vld_q & ~cap_idle & no_credit;
	assign push_blk_o = cap_q;

	// Credits track free buffer slots
	always_ff @(posedge rx_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			credit_q <= lb_credit_t'(`LB_DEPTH);
		end else begin
			case ({push_o, credit_ret_i})
				2'b10:   credit_q <= credit_q - lb_credit_t'(1);
				2'b01:   credit_q <= credit_q + lb_credit_t'(1);
				default: credit_q <= credit_q;  // Both or neither
			endcase
		end
	end

	// Saturating drop counter
	always_ff @(posedge rx_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ovf_cnt_o <= '0;
		end else if (drop_ovf && (ovf_cnt_o != '1)) begin
			ovf_cnt_o <= ovf_cnt_o + lb_count_t'(1);
		end
	end

endmodule

//--- logic/pcs_tx_emit.sv
// PCS TX emitter
// Feeds buffered blocks to the TX PCS, fills with idles when the
// buffer is empty and holds its output while the TX gearbox pauses.
// Releases the TX PCS reset two cycles after the loopback reset
`timescale 1ns/1ns

module pcs_tx_emit (
	input  logic                      rx_clk,
	input  logic                      rst_n_i,
	input  pcs_types_pkg::pcs_block_t head_blk_i,
	input  logic                      not_empty_i,
	input  logic                      tx_ready_i,
	output logic                      pop_o,
	output pcs_types_pkg::pcs_block_t tx_blk_o,
	output logic                      tx_nreset_o
);
	import pcs_types_pkg::*;
	import loopback_ctrl_pkg::*;

	// Control block with only the idle flag raised
	localparam pcs_block_t IDLE_BLK = '{ctrl: 1'b1, idle: 1'b1, default: '0};

	emit_state_t state_q;
	emit_state_t state_d;
	logic        run;

	// --------------------
	// Reset sequencing
	// --------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			EMIT_RESET: state_d = EMIT_WAKE;
			EMIT_WAKE:  state_d = EMIT_RUN;
			EMIT_RUN:   state_d = EMIT_RUN;
			default:    state_d = EMIT_RESET;
		endcase
	end

	always_ff @(posedge rx_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= EMIT_RESET;
		end else begin
			state_q <= state_d;
		end
	end

	assign run         = (state_q == EMIT_RUN);
	assign tx_nreset_o = run;  // High from the second edge after release

	// --------------------
	// Output stage
	// --------------------
	assign pop_o = run & not_empty_i & tx_ready_i;

	// Holds under back-pressure, idle fill when empty
	always_ff @(posedge rx_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tx_blk_o <= IDLE_BLK;
		end else if (run && tx_ready_i) begin
			if (not_empty_i) begin
				tx_blk_o <= head_blk_i;
			end else begin
				tx_blk_o <= IDLE_BLK;
			end
		end
	end

endmodule

//--- logic/pcs_types_pkg.sv
// PCS block types
// Describes one decoded block as it leaves the RX PCS and enters
// the TX PCS, single lane

`include "loopback_consts.svh"

package pcs_types_pkg;

	// --------------------
	// Field widths
	// --------------------
	typedef logic [`PCS_DATA_W-1:0]  pcs_data_t;   // Block payload
	typedef logic [`PCS_KEEP_W-1:0]  pcs_keep_t;   // Byte valid mask
	typedef logic [`PCS_START_W-1:0] pcs_start_t;  // Start position flags

	// --------------------
	// Decoded block
	// --------------------
	typedef struct packed {
		logic       ctrl;    // Block carries control characters
		logic       idle;    // Idle block
		logic       term;    // Terminate character present
		logic       err;     // Decode error
		pcs_start_t start;   // Start on lane 0 or lane 4
		pcs_keep_t  keep;    // Valid data bytes
		pcs_data_t  data;    // Payload
	} pcs_block_t;

endpackage

//--- pcs_loopback_top.f
+incdir+logic
logic/pcs_types_pkg.sv
logic/loopback_ctrl_pkg.sv
logic/pcs_rx_capture.sv
logic/loopback_fifo.sv
logic/pcs_tx_emit.sv
logic/pcs_loopback_top.sv
tests/pcs_loopback_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the PCS loopback testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
	--top-module pcs_loopback_tb --Mdir obj_dir -f pcs_loopback_top.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vpcs_loopback_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- tests/pcs_loopback_tb.sv
// PCS loopback testbench
// Sends seeded random data and idle blocks through the loopback path and
// compares the returned data blocks, in order, against a queue model.
// Covers reset release, back-pressure, overflow drops and idle fill
`timescale 1ns/1ns
`include "loopback_consts.svh"

module pcs_loopback_tb;
	import pcs_types_pkg::*;
	import loopback_ctrl_pkg::*;

	localparam int TIMEOUT = 2000;               // Cycles allowed per wait
	localparam int CHK_W   = $bits(pcs_block_t);

	typedef logic [CHK_W-1:0] chk_t;

	logic       rx_clk;
	logic       rst_n_i;
	pcs_block_t rx_blk_i;
	logic       rx_valid_i;
	logic       tx_ready_i;
	pcs_block_t tx_blk_o;
	logic       tx_nreset_o;
	lb_count_t  ovf_cnt_o;

	pcs_block_t idle_blk;
	pcs_block_t exp_blk;
	pcs_block_t exp_q[$];       // Data blocks still owed by the DUT
	integer     seed;
	int         err_cnt = 0;
	int         load_cnt = 0;   // Output register loads seen
	logic       load_next;      // Output register loads on the coming edge
	string      test_name;

	pcs_loopback_top u_pcs_loopback_top (
		.rx_clk      (rx_clk),
		.rst_n_i     (rst_n_i),
		.rx_blk_i    (rx_blk_i),
		.rx_valid_i  (rx_valid_i),
		.tx_ready_i  (tx_ready_i),
		.tx_blk_o    (tx_blk_o),
		.tx_nreset_o (tx_nreset_o),
		.ovf_cnt_o   (ovf_cnt_o)
	);

	initial rx_clk = 1'b0;
	always #20 rx_clk = ~rx_clk;  // 40 ns period

	// --------------------
	// Helpers
	// --------------------
	function automatic logic is_idle(input pcs_block_t b);
		return b.ctrl && b.idle;
	endfunction

	function automatic logic chance(input int unsigned pct);
		int unsigned r;
		r = $random(seed);
		return (r % 100) < pct;
	endfunction

	// Random block that never carries the idle marking
	function automatic pcs_block_t rand_data_blk();
		pcs_block_t b;
		b.data  = {$random(seed), $random(seed)};
		b.keep  = pcs_keep_t'($random(seed));
		b.start = pcs_start_t'($random(seed));
		b.ctrl  = 1'($random(seed));
		b.idle  = 1'($random(seed)) & ~b.ctrl;
		b.term  = 1'($random(seed));
		b.err   = 1'($random(seed));
		return b;
	endfunction

	task automatic stop_run();
		$display("Result: FAILED");
		$fatal(1, "testbench stopped at first error");
	endtask

	task automatic check_value(input string name, input chk_t expected, input chk_t actual);
		if (expected !== actual) begin
			err_cnt++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic report_timeout(input string what);
		err_cnt++;
		$display("Timed out in %s while waiting for %s", test_name, what);
		stop_run();
	endtask

	task automatic drive_cycle(input logic valid, input pcs_block_t blk, input logic ready);
		@(posedge rx_clk);
		rx_valid_i <= valid;
		rx_blk_i   <= blk;
		tx_ready_i <= ready;
	endtask

	// Every data block sent here must come back
	task automatic send_block(input pcs_block_t blk, input logic ready);
		if (!is_idle(blk)) begin
			exp_q.push_back(blk);
		end
		drive_cycle(1'b1, blk, ready);
	endtask

	// Input off, TX ready; enough loads to empty capture stage and buffer
	task automatic drain_buffer();
		int start;
		int cycles;
		drive_cycle(1'b0, idle_blk, 1'b1);
		start  = load_cnt;
		cycles = 0;
		while (exp_q.size() != 0 || (load_cnt - start) < `LB_DEPTH + 2) begin
			@(posedge rx_clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				report_timeout("the buffer to drain");
			end
		end
	endtask

	// --------------------
	// Output monitor
	// --------------------
	always @(negedge rx_clk) begin
		if (rst_n_i && load_next) begin
			load_cnt++;
			if (!is_idle(tx_blk_o)) begin
				if (exp_q.size() == 0) begin
					err_cnt++;
					$display("Data block %h left the loopback but none was expected", tx_blk_o);
					stop_run();
				end else begin
					exp_blk = exp_q.pop_front();
					check_value(test_name, chk_t'(exp_blk), chk_t'(tx_blk_o));
				end
			end
		end
		load_next = rst_n_i && tx_ready_i;  // Sampled for the next edge
	end

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		pcs_block_t  blk;
		int unsigned n_data;
		int          wait_cnt;
		logic        ready;
		logic        prev_ready;
		logic        prev_data;

		seed       = 32'h2c1b_d3af;
		idle_blk   = '0;
		idle_blk.ctrl = 1'b1;
		idle_blk.idle = 1'b1;
		rst_n_i    <= 1'b0;
		rx_valid_i <= 1'b0;
		rx_blk_i   <= '0;
		tx_ready_i <= 1'b0;

		test_name = "reset";
		repeat (5) begin
			@(negedge rx_clk);
			check_value(test_name, chk_t'(idle_blk), chk_t'(tx_blk_o));
			check_value(test_name, chk_t'(0), chk_t'(ovf_cnt_o));
			check_value(test_name, chk_t'(0), chk_t'(tx_nreset_o));
		end
		@(posedge rx_clk);
		rst_n_i <= 1'b1;
		test_name = "reset release";
		for (int i = 1; i <= 3; i++) begin
			@(negedge rx_clk);
			check_value(test_name, chk_t'(i == 3), chk_t'(tx_nreset_o));  // High 2 cycles on
			check_value(test_name, chk_t'(idle_blk), chk_t'(tx_blk_o));
			check_value(test_name, chk_t'(0), chk_t'(ovf_cnt_o));
		end

		test_name = "straight loopback";
		n_data = 0;
		while (n_data < 200) begin
			if (chance(50)) begin
				send_block(rand_data_blk(), 1'b1);
				n_data++;
			end else begin
				send_block(idle_blk, 1'b1);
			end
		end
		drain_buffer();
		check_value(test_name, chk_t'(0), chk_t'(ovf_cnt_o));

		// Ready never low twice running, data never back to back
		test_name  = "random back-pressure";
		n_data     = 0;
		prev_ready = 1'b1;
		prev_data  = 1'b0;
		while (n_data < 200) begin
			ready = chance(75) || !prev_ready;
			if (!prev_data && chance(50)) begin
				send_block(rand_data_blk(), ready);
				n_data++;
				prev_data = 1'b1;
			end else begin
				send_block(idle_blk, ready);
				prev_data = 1'b0;
			end
			prev_ready = ready;
		end
		drain_buffer();
		check_value(test_name, chk_t'(0), chk_t'(ovf_cnt_o));

		test_name = "overflow";
		for (int i = 0; i < `LB_DEPTH + 5; i++) begin
			blk = rand_data_blk();
			if (i < `LB_DEPTH) begin
				exp_q.push_back(blk);  // The rest finds no credit
			end
			drive_cycle(1'b1, blk, 1'b0);
		end
		drive_cycle(1'b0, idle_blk, 1'b0);
		wait_cnt = 0;
		do begin
			@(negedge rx_clk);
			wait_cnt++;
			if (wait_cnt > TIMEOUT) begin
				report_timeout("the overflow count");
			end
		end while (ovf_cnt_o < lb_count_t'(5));
		check_value(test_name, chk_t'(5), chk_t'(ovf_cnt_o));
		drain_buffer();
		check_value(test_name, chk_t'(5), chk_t'(ovf_cnt_o));

		test_name = "idle insertion";
		drain_buffer();
		@(negedge rx_clk);
		check_value(test_name, chk_t'(idle_blk), chk_t'(tx_blk_o));

		if (err_cnt == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule
